// ==== flist.f ====
rtl/cam_link_pkg.sv
rtl/link_fsm.sv
rtl/cam_mem_port.sv
rtl/tpdu_receiver.sv
rtl/buffer_tracker.sv
rtl/cam_link_top.sv
dv/cam_mem_model.sv
dv/cam_link_tb.sv

// ==== dv/cam_link_tb.sv ====
`timescale 1ns/1ps

module cam_link_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int TMO_CYCLES      = 100;   // Short negotiation timeout
    localparam int NUM_ROWS        = 5;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 2000 + 4 * TMO_CYCLES + 500;

    // One TPDU case, data bytes first in the top byte
    typedef struct packed {
        cam_link_pkg::tpdu_byte_t tag;
        logic [2:0]               len;   // 0 to 6 data bytes
        logic [47:0]              data;
    } tpdu_row_t;

    localparam tpdu_row_t [0:NUM_ROWS-1] TPDU_TABLE = {
        {8'hA0, 3'd2, 48'hC1C2_0000_0000},
        {8'hA1, 3'd0, 48'h0000_0000_0000},  // Header only
        {8'h81, 3'd6, 48'h0102_0304_0506},
        {8'hA0, 3'd1, 48'hFF00_0000_0000},
        {8'h83, 3'd4, 48'h5AA5_3CC3_0000}
    };

    logic                     clk;
    logic                     rst_n;
    cam_link_pkg::mem_req_t   mem_req;
    cam_link_pkg::mem_word_t  mem_rdata;
    logic                     mem_ready;
    cam_link_pkg::host_byte_t host_tx;
    logic                     tx_busy;
    cam_link_pkg::rx_byte_t   rx;
    cam_link_pkg::tpdu_byte_t rx_tag;
    cam_link_pkg::buf_len_t   rx_length;
    logic                     link_init;
    cam_link_pkg::buf_len_t   buffer_size;
    logic                     session_close_req;
    logic                     link_ready;
    logic                     link_error;
    logic                     session_open;
    cam_link_pkg::buf_len_t   session_number;
    logic                     withhold;

    int error_count  = 0;
    int test_count   = 0;
    int failed_tests = 0;

    cam_link_top #(
        .TIMEOUT_CYCLES(TMO_CYCLES)
    ) cam_link_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_req           (mem_req),
        .mem_rdata         (mem_rdata),
        .mem_ready         (mem_ready),
        .host_tx           (host_tx),
        .tx_busy           (tx_busy),
        .rx                (rx),
        .rx_tag            (rx_tag),
        .rx_length         (rx_length),
        .link_init         (link_init),
        .buffer_size       (buffer_size),
        .session_close_req (session_close_req),
        .link_ready        (link_ready),
        .link_error        (link_error),
        .session_open      (session_open),
        .session_number    (session_number)
    );

    cam_mem_model #(
        .SEED(32'h5214_339e)
    ) cam_mem_model_i (
        .clk       (clk),
        .mem_req   (mem_req),
        .withhold  (withhold),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("PASS  %s", name);
        end else begin
            failed_tests++;
            $display("FAIL  %s (%0d errors)", name, error_count - errors_at_start);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;  // Drive and sample away from the edge
    endtask

    // Byte i of the whole TPDU, header included
    function automatic cam_link_pkg::tpdu_byte_t tpdu_byte_at(input tpdu_row_t row,
                                                               input int i);
        if (i == 0) begin
            return row.tag;
        end else if (i == 1) begin
            return 8'h00;  // Length high byte
        end else if (i == 2) begin
            return {5'd0, row.len};
        end
        return row.data[47 - 8 * (i - 3) -: 8];
    endfunction

    // Present one byte and hold it until the write is taken
    task automatic send_byte(input cam_link_pkg::tpdu_byte_t data, input logic first,
                             input logic last);
        host_tx.valid = 1'b1;
        host_tx.data  = data;
        host_tx.first = first;
        host_tx.last  = last;
        do next_cycle(); while (!tx_busy);
        compare_value("host write word", mem_req.wdata, {8'h00, data});  // Upper byte zero
        while (tx_busy) next_cycle();
    endtask

    task automatic send_tpdu(input tpdu_row_t row, input int base);
        int total;
        total = row.len + 3;
        for (int i = 0; i < total; i++) begin
            send_byte(tpdu_byte_at(row, i), i == 0, i == total - 1);
        end
        host_tx = '0;
        for (int i = 0; i < total; i++) begin
            compare_value($sformatf("buffer byte %0d", base + i),
                          cam_mem_model_i.common_mem[cam_link_pkg::DATA_BUF_ADDR + base + i],
                          tpdu_byte_at(row, i));
        end
    endtask

    task automatic receive_tpdu(input tpdu_row_t row);
        int n;
        bit seen_first;
        bit seen_last;
        n          = 0;
        seen_first = 1'b0;
        seen_last  = 1'b0;
        while (!seen_last) begin
            next_cycle();
            if (rx.first) begin
                compare_value("rx_tag", rx_tag, row.tag);
                seen_first = 1'b1;
            end
            if (rx.valid) begin
                compare_value($sformatf("rx data byte %0d", n), rx.data,
                              tpdu_byte_at(row, n + 3));
                n++;
            end
            if (rx.last) begin
                seen_last = 1'b1;
                compare_value("rx.last with final data byte", rx.valid, row.len != 0);
            end
        end
        compare_value("rx.first seen", seen_first, 1'b1);
        compare_value("rx_length", rx_length, row.len);
        compare_value("rx data byte count", n, row.len);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        int errors_at_start;
        int base;
        int cycles;
        rst_n             = 1'b0;
        host_tx           = '0;
        link_init         = 1'b0;
        buffer_size       = 16'h0400;
        session_close_req = 1'b0;
        withhold          = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        errors_at_start = error_count;
        next_cycle();
        compare_value("mem_req.read", mem_req.read, 1'b0);
        compare_value("mem_req.write", mem_req.write, 1'b0);
        compare_value("rx flags", {rx.valid, rx.first, rx.last}, 3'b000);
        compare_value("link_ready", link_ready, 1'b0);
        compare_value("link_error", link_error, 1'b0);
        compare_value("session_open", session_open, 1'b0);
        compare_value("tx_busy", tx_busy, 1'b0);
        finish_test("reset", errors_at_start);

        // Size write, create-TC write, then session 1
        errors_at_start = error_count;
        link_init = 1'b1;
        while (!link_ready) next_cycle();
        compare_value("session_open", session_open, 1'b1);
        compare_value("session_number", session_number, 16'd1);
        compare_value("size write", cam_mem_model_i.attr_mem[cam_link_pkg::SIZE_LS_ADDR],
                      buffer_size);
        compare_value("create-TC write",
                      cam_mem_model_i.common_mem[cam_link_pkg::DATA_BUF_ADDR],
                      cam_link_pkg::TAG_CREATE_TC);
        finish_test("bring-up", errors_at_start);

        base = 0;  // TPDUs follow each other in the buffer
        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_at_start = error_count;
            send_tpdu(TPDU_TABLE[r], base);
            receive_tpdu(TPDU_TABLE[r]);
            base += TPDU_TABLE[r].len + 3;
            finish_test($sformatf("tpdu row %0d", r), errors_at_start);
        end

        errors_at_start = error_count;
        next_cycle();  // Back in ACTIVE
        session_close_req = 1'b1;
        link_init         = 1'b0;  // Stay in IDLE afterwards
        next_cycle();
        session_close_req = 1'b0;
        next_cycle();
        compare_value("session_open after close", session_open, 1'b0);
        compare_value("link_ready after close", link_ready, 1'b0);
        finish_test("session close", errors_at_start);

        // Size write never completes
        errors_at_start = error_count;
        withhold  = 1'b1;
        link_init = 1'b1;
        cycles    = 0;
        while (!link_error) begin
            next_cycle();
            cycles++;
        end
        compare_value("timeout not before limit", cycles >= TMO_CYCLES, 1'b1);
        link_init = 1'b0;
        cycles    = 0;
        while (link_error && cycles < 4) begin
            next_cycle();
            cycles++;
        end
        compare_value("link_error after link_init low", link_error, 1'b0);
        finish_test("timeout", errors_at_start);

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run hung waiting on the DUT",
                 WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== dv/cam_mem_model.sv ====
`timescale 1ns/1ps

module cam_mem_model #(
    parameter int unsigned SEED = 32'h1  // Ready delay seed
) (
    input  logic                    clk,
    input  cam_link_pkg::mem_req_t  mem_req,
    input  logic                    withhold,   // Suppress mem_ready entirely
    output cam_link_pkg::mem_word_t mem_rdata,
    output logic                    mem_ready
);

    cam_link_pkg::tpdu_byte_t common_mem [0:2047];  // One byte per address
    cam_link_pkg::mem_word_t  attr_mem   [0:1023];

    // Strobe seen on an edge, ready 1 to 3 edges later
    initial begin
        int unsigned             seed;
        int unsigned             wait_cnt;
        cam_link_pkg::mem_word_t rd_word;
        seed      = SEED;
        wait_cnt  = 0;
        rd_word   = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        void'($urandom(seed));  // Once for the whole run
        forever begin
            @(posedge clk);
            mem_ready <= 1'b0;  // Single-cycle pulse
            if (mem_req.write && mem_req.attr) begin
                attr_mem[mem_req.addr[9:0]] = mem_req.wdata;
            end else if (mem_req.write) begin
                common_mem[mem_req.addr[10:0]] = mem_req.wdata[7:0];  // Upper byte unused
            end else if (mem_req.read) begin
                rd_word = {8'h00, common_mem[mem_req.addr[10:0]]};
            end
            if (mem_req.read || mem_req.write) begin
                wait_cnt = 1 + ($urandom % 3);
            end
            if (wait_cnt != 0) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0 && !withhold) begin
                    mem_ready <= 1'b1;
                    mem_rdata <= rd_word;
                end
            end
        end
    end

endmodule

// ==== rtl/cam_link_top.sv ====
`timescale 1ns/1ps

module cam_link_top #(
    parameter int TIMEOUT_CYCLES = 255  // Negotiation timeout in cycles
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // CAM memory port
    output cam_link_pkg::mem_req_t   mem_req,
    input  cam_link_pkg::mem_word_t  mem_rdata,
    input  logic                     mem_ready,
    // Host transmit side
    input  cam_link_pkg::host_byte_t host_tx,
    output logic                     tx_busy,
    // Receive side
    output cam_link_pkg::rx_byte_t   rx,
    output cam_link_pkg::tpdu_byte_t rx_tag,
    output cam_link_pkg::buf_len_t   rx_length,
    // Link control and session
    input  logic                     link_init,
    input  cam_link_pkg::buf_len_t   buffer_size,
    input  logic                     session_close_req,
    output logic                     link_ready,
    output logic                     link_error,
    output logic                     session_open,
    output cam_link_pkg::buf_len_t   session_number
);

    cam_link_pkg::link_state_e state;
    logic                      done;        // Access finished this cycle
    cam_link_pkg::buf_len_t    write_ptr;
    cam_link_pkg::buf_len_t    read_ptr;
    cam_link_pkg::buf_len_t    data_count;
    cam_link_pkg::buf_len_t    rx_offset;   // Next byte to fetch
    logic                      rx_fetch;

    link_fsm #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) link_fsm_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .link_init         (link_init),
        .session_close_req (session_close_req),
        .host_tx           (host_tx),
        .done              (done),
        .busy              (tx_busy),    // Pending flag doubles as host busy
        .data_count        (data_count),
        .rx                (rx),
        .state             (state),
        .link_ready        (link_ready),
        .link_error        (link_error),
        .session_open      (session_open),
        .session_number    (session_number)
    );

    cam_mem_port cam_mem_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .buffer_size (buffer_size),
        .host_tx     (host_tx),
        .write_ptr   (write_ptr),
        .read_ptr    (read_ptr),
        .rx_offset   (rx_offset),
        .rx_fetch    (rx_fetch),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .done        (done),
        .busy        (tx_busy)
    );

    tpdu_receiver tpdu_receiver_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .done      (done),
        .mem_rdata (mem_rdata),
        .rx        (rx),
        .rx_tag    (rx_tag),
        .rx_length (rx_length),
        .rx_offset (rx_offset),
        .rx_fetch  (rx_fetch)
    );

    buffer_tracker buffer_tracker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .done       (done),
        .rx         (rx),
        .rx_length  (rx_length),
        .write_ptr  (write_ptr),
        .read_ptr   (read_ptr),
        .data_count (data_count)
    );

endmodule

// ==== rtl/buffer_tracker.sv ====
`timescale 1ns/1ps

module buffer_tracker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cam_link_pkg::link_state_e state,
    input  logic                      done,
    input  cam_link_pkg::rx_byte_t    rx,
    input  cam_link_pkg::buf_len_t    rx_length,
    output cam_link_pkg::buf_len_t    write_ptr,
    output cam_link_pkg::buf_len_t    read_ptr,
    output cam_link_pkg::buf_len_t    data_count
);

    cam_link_pkg::buf_len_t tpdu_size;  // Whole TPDU incl. header

    assign tpdu_size = rx_length + cam_link_pkg::TPDU_HDR_BYTES;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_ptr  <= '0;
            read_ptr   <= '0;
            data_count <= '0;
        end else if (state == cam_link_pkg::IDLE) begin
            write_ptr  <= '0;   // Fresh buffer per link
            read_ptr   <= '0;
            data_count <= '0;
        end else if (state == cam_link_pkg::WRITE_TPDU && done) begin
            write_ptr  <= write_ptr + 1'b1;   // One byte per write
            data_count <= data_count + 1'b1;
        end else if (rx.last) begin
            read_ptr   <= read_ptr + tpdu_size;  // Skip the consumed TPDU
            data_count <= data_count - tpdu_size;
        end
    end

endmodule

// ==== rtl/tpdu_receiver.sv ====
`timescale 1ns/1ps

module tpdu_receiver (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cam_link_pkg::link_state_e state,
    input  logic                      done,
    input  cam_link_pkg::mem_word_t   mem_rdata,
    output cam_link_pkg::rx_byte_t    rx,
    output cam_link_pkg::tpdu_byte_t  rx_tag,
    output cam_link_pkg::buf_len_t    rx_length,
    output cam_link_pkg::buf_len_t    rx_offset,
    output logic                      rx_fetch
);

    cam_link_pkg::tpdu_byte_t byte_in;   // Low byte of the read word
    cam_link_pkg::buf_len_t   data_idx;  // Position within the data field

    assign byte_in  = mem_rdata[7:0];
    assign data_idx = rx_offset - cam_link_pkg::TPDU_HDR_BYTES;
    // Header always, then data until the length is used up
    assign rx_fetch = (rx_offset < cam_link_pkg::TPDU_HDR_BYTES) || (data_idx < rx_length);

    // ============================================================
    // Byte parser
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx        <= '0;
            rx_tag    <= '0;
            rx_length <= '0;
            rx_offset <= '0;
        end else begin
            rx.valid <= 1'b0;  // Flags are single-cycle pulses
            rx.first <= 1'b0;
            rx.last  <= 1'b0;
            if (state != cam_link_pkg::READ_TPDU) begin
                rx_offset <= '0;
            end else if (done) begin
                rx_offset <= rx_offset + 1'b1;
                case (rx_offset)
                    16'd0: begin
                        rx_tag   <= byte_in;
                        rx.first <= 1'b1;
                    end
                    16'd1: rx_length[15:8] <= byte_in;  // Length is big endian
                    16'd2: begin
                        rx_length[7:0] <= byte_in;
                        // Empty TPDU ends on the header
                        rx.last <= ({rx_length[15:8], byte_in} == '0);
                    end
                    default: begin
                        rx.valid <= 1'b1;
                        rx.data  <= byte_in;
                        rx.last  <= (data_idx + 1'b1 == rx_length);
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/cam_mem_port.sv ====
`timescale 1ns/1ps

module cam_mem_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cam_link_pkg::link_state_e state,
    input  cam_link_pkg::buf_len_t    buffer_size,
    input  cam_link_pkg::host_byte_t  host_tx,
    input  cam_link_pkg::buf_len_t    write_ptr,
    input  cam_link_pkg::buf_len_t    read_ptr,
    input  cam_link_pkg::buf_len_t    rx_offset,
    input  logic                      rx_fetch,
    input  logic                      mem_ready,
    output cam_link_pkg::mem_req_t    mem_req,
    output logic                      done,
    output logic                      busy
);

    logic                    pending;     // One access in flight
    logic                    issue_rd;
    logic                    issue_wr;
    cam_link_pkg::mem_addr_t next_addr;
    cam_link_pkg::mem_word_t next_wdata;
    logic                    next_attr;

    assign done = pending && mem_ready;  // Ready only counts while pending
    assign busy = pending;

    // ============================================================
    // Access select per state
    // ============================================================

    always_comb begin
        issue_rd   = 1'b0;
        issue_wr   = 1'b0;
        next_attr  = 1'b0;   // Common memory unless size write
        next_addr  = cam_link_pkg::DATA_BUF_ADDR + write_ptr;
        next_wdata = {8'h00, host_tx.data};
        if (!pending) begin
            case (state)
                cam_link_pkg::INIT: begin
                    issue_wr   = 1'b1;
                    next_attr  = 1'b1;
                    next_addr  = cam_link_pkg::SIZE_LS_ADDR;
                    next_wdata = buffer_size;
                end
                cam_link_pkg::WAIT_LINK: begin
                    issue_wr   = 1'b1;
                    next_addr  = cam_link_pkg::DATA_BUF_ADDR;
                    next_wdata = {8'h00, cam_link_pkg::TAG_CREATE_TC};
                end
                // First host byte goes out on the ACTIVE exit edge
                cam_link_pkg::ACTIVE:     issue_wr = host_tx.valid && host_tx.first;
                cam_link_pkg::WRITE_TPDU: issue_wr = host_tx.valid;
                cam_link_pkg::READ_TPDU: begin
                    issue_rd  = rx_fetch;
                    next_addr = cam_link_pkg::DATA_BUF_ADDR + read_ptr + rx_offset;
                end
                default: ;
            endcase
        end
    end

    // Strobes last one cycle, address and data hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req <= '0;
            pending <= 1'b0;
        end else begin
            mem_req.read  <= issue_rd;
            mem_req.write <= issue_wr;
            if (issue_rd || issue_wr) begin
                mem_req.addr  <= next_addr;
                mem_req.wdata <= next_wdata;
                mem_req.attr  <= next_attr;
                pending       <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/link_fsm.sv ====
`timescale 1ns/1ps

module link_fsm #(
    parameter int TIMEOUT_CYCLES = 255
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      link_init,
    input  logic                      session_close_req,
    input  cam_link_pkg::host_byte_t  host_tx,
    input  logic                      done,
    input  logic                      busy,
    input  cam_link_pkg::buf_len_t    data_count,
    input  cam_link_pkg::rx_byte_t    rx,
    output cam_link_pkg::link_state_e state,
    output logic                      link_ready,
    output logic                      link_error,
    output logic                      session_open,
    output cam_link_pkg::buf_len_t    session_number
);

    localparam int TW = $clog2(TIMEOUT_CYCLES + 1);  // Timeout counter width

    cam_link_pkg::link_state_e next_state;
    logic [TW-1:0]             tmo_cnt;
    logic                      tmo_hit;
    logic                      host_start;   // Host opens a new TPDU
    logic                      negotiating;

    assign host_start  = host_tx.valid && host_tx.first && !busy;
    assign negotiating = (state == cam_link_pkg::SIZE_NEG) ||
                         (state == cam_link_pkg::CREATE_TC);
    assign tmo_hit     = (tmo_cnt == TW'(TIMEOUT_CYCLES - 1));

    // ============================================================
    // State register and next state
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cam_link_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;  // Hold by default
        case (state)
            cam_link_pkg::IDLE:       if (link_init) next_state = cam_link_pkg::INIT;
            cam_link_pkg::INIT:       if (!busy) next_state = cam_link_pkg::SIZE_NEG;
            cam_link_pkg::SIZE_NEG: begin
                if (done) begin
                    next_state = cam_link_pkg::WAIT_LINK;  // Size write accepted
                end else if (tmo_hit) begin
                    next_state = cam_link_pkg::ERROR;
                end
            end
            cam_link_pkg::WAIT_LINK:  if (!busy) next_state = cam_link_pkg::CREATE_TC;
            cam_link_pkg::CREATE_TC: begin
                if (done) begin
                    next_state = cam_link_pkg::ACTIVE;
                end else if (tmo_hit) begin
                    next_state = cam_link_pkg::ERROR;
                end
            end
            cam_link_pkg::ACTIVE: begin
                // Host traffic first, then close, then pending receive data
                if (host_start) begin
                    next_state = cam_link_pkg::WRITE_TPDU;
                end else if (session_close_req) begin
                    next_state = cam_link_pkg::DELETE_TC;
                end else if (data_count != '0) begin
                    next_state = cam_link_pkg::READ_TPDU;
                end
            end
            cam_link_pkg::READ_TPDU:  if (rx.last) next_state = cam_link_pkg::ACTIVE;
            cam_link_pkg::WRITE_TPDU: if (done && host_tx.last) next_state = cam_link_pkg::ACTIVE;
            cam_link_pkg::DELETE_TC:  next_state = cam_link_pkg::IDLE;
            cam_link_pkg::ERROR:      if (!link_init) next_state = cam_link_pkg::IDLE;
            default:                  next_state = cam_link_pkg::IDLE;
        endcase
    end

    // Runs only while a negotiation write is outstanding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmo_cnt <= '0;
        end else if (!negotiating) begin
            tmo_cnt <= '0;
        end else if (!tmo_hit) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    // ============================================================
    // Session and status outputs
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            session_open   <= 1'b0;
            session_number <= '0;
            link_ready     <= 1'b0;
            link_error     <= 1'b0;
        end else begin
            if (state == cam_link_pkg::CREATE_TC && done) begin
                session_open   <= 1'b1;
                session_number <= cam_link_pkg::buf_len_t'(1);  // Single session
            end else if (state == cam_link_pkg::DELETE_TC) begin
                session_open   <= 1'b0;
                session_number <= '0;
            end
            // Ready stays up across transfers
            link_ready <= (state == cam_link_pkg::ACTIVE) ||
                          (state == cam_link_pkg::READ_TPDU) ||
                          (state == cam_link_pkg::WRITE_TPDU);
            link_error <= (state == cam_link_pkg::ERROR);
        end
    end

endmodule

// ==== rtl/cam_link_pkg.sv ====
package cam_link_pkg;

    // ============================================================
    // Widths
    // ============================================================

    typedef logic [25:0] mem_addr_t;   // PCMCIA address
    typedef logic [15:0] mem_word_t;   // Memory data word
    typedef logic [7:0]  tpdu_byte_t;  // One TPDU byte
    typedef logic [15:0] buf_len_t;    // Sizes, pointers, counts

    // ============================================================
    // Addresses and protocol constants
    // ============================================================

    localparam mem_addr_t  SIZE_LS_ADDR   = 26'h000200; // Buffer size reg, attribute space
    localparam mem_addr_t  DATA_BUF_ADDR  = 26'h000600; // Data buffer base, common space
    localparam tpdu_byte_t TAG_CREATE_TC  = 8'h82;      // Create transport connection
    localparam buf_len_t   TPDU_HDR_BYTES = 16'd3;      // Tag plus two length bytes

    // Link controller states
    typedef enum logic [3:0] {
        IDLE,
        INIT,       // Size write goes out here
        SIZE_NEG,   // Waiting on size write
        WAIT_LINK,  // Create-TC write goes out here
        CREATE_TC,  // Waiting on create-TC write
        ACTIVE,
        READ_TPDU,
        WRITE_TPDU,
        DELETE_TC,
        ERROR
    } link_state_e;

    // ============================================================
    // Bundles
    // ============================================================

    typedef struct packed {
        mem_addr_t addr;
        mem_word_t wdata;
        logic      read;   // One-cycle strobe
        logic      write;  // One-cycle strobe
        logic      attr;   // Attribute memory select
    } mem_req_t;

    // Byte from the host, held until tx_busy falls
    typedef struct packed {
        logic       valid;
        tpdu_byte_t data;
        logic       first;
        logic       last;
    } host_byte_t;

    typedef struct packed {
        logic       valid;  // Data byte strobe
        tpdu_byte_t data;
        logic       first;  // With the tag byte
        logic       last;   // With the final data byte
    } rx_byte_t;

endpackage
